// ==== verilog/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    // widths seen by the cpu and memory sides
    typedef logic [31:0]  addr_t;       // byte address
    typedef logic [63:0]  word_t;       // cpu doubleword, also one bus beat
    typedef logic [127:0] line_t;       // 16-byte cache line
    typedef logic [15:0]  line_strb_t;  // byte strobe over a line
    typedef logic [7:0]   word_strb_t;  // byte strobe over a doubleword

    // bus transfer type
    // 0..3 are single accesses of 1, 2, 4 and 8 bytes, taken from size_i
    typedef logic [2:0] xfer_type_t;

    localparam xfer_type_t XFER_LINE = 3'd4;  // two-beat line transfer

    // controller states
    typedef enum logic [2:0] {
        S_IDLE,     // waiting for a request
        S_LOOKUP,   // hit being served
        S_MISS,     // victim writeback or uncached store
        S_REPLACE,  // read address phase
        S_REFILL    // collecting read beats
    } dcache_state_t;

endpackage

`default_nettype wire

// ==== verilog/dcache_tag_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_tag_array import dcache_pkg::*; #(
    parameter int INDEX_W = 7
) (
    input  wire                   clk,
    input  wire                   rst,
    input  addr_t                 lookup_addr_i,
    input  wire [INDEX_W-1:0]     victim_index_i,
    input  wire                   update_i,
    input  wire                   update_way_i,
    input  wire [27-INDEX_W:0]    update_tag_i,
    input  wire                   set_dirty_i,
    input  wire                   touch_i,
    input  wire                   touch_way_i,
    output logic                  hit_way0_o,
    output logic                  hit_way1_o,
    output logic                  victim_way_o,
    output logic                  victim_dirty_o,
    output logic [27-INDEX_W:0]   victim_tag_o
);

    localparam int TAG_W = 28 - INDEX_W;
    localparam int SETS  = 1 << INDEX_W;

    logic [TAG_W-1:0] tag_mem [2][SETS];
    logic [SETS-1:0]  valid_q [2];
    logic [SETS-1:0]  dirty_q [2];
    logic [SETS-1:0]  ru_q;             // 1 when way1 was used last

    logic [INDEX_W-1:0] l_index;
    logic [TAG_W-1:0]   l_tag;

    assign l_index = lookup_addr_i[INDEX_W+3:4];
    assign l_tag   = lookup_addr_i[31:INDEX_W+4];

    assign hit_way0_o = valid_q[0][l_index] && (tag_mem[0][l_index] == l_tag);
    assign hit_way1_o = valid_q[1][l_index] && (tag_mem[1][l_index] == l_tag);

    // first free way, else the one not used last
    always_comb begin
        if (!valid_q[0][victim_index_i]) begin
            victim_way_o = 1'b0;
        end else if (!valid_q[1][victim_index_i]) begin
            victim_way_o = 1'b1;
        end else begin
            victim_way_o = ~ru_q[victim_index_i];
        end
    end

    assign victim_dirty_o = dirty_q[victim_way_o][victim_index_i];
    assign victim_tag_o   = tag_mem[victim_way_o][victim_index_i];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '{default: '0};
            dirty_q <= '{default: '0};
            ru_q    <= '0;
        end else if (update_i) begin  // refill of a new line
            valid_q[update_way_i][victim_index_i] <= 1'b1;
            dirty_q[update_way_i][victim_index_i] <= set_dirty_i;
            ru_q[victim_index_i]                  <= update_way_i;
        end else if (touch_i) begin
            ru_q[victim_index_i] <= touch_way_i;
            if (set_dirty_i) begin  // store hit
                dirty_q[touch_way_i][victim_index_i] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (update_i) begin
            tag_mem[update_way_i][victim_index_i] <= update_tag_i;
        end
    end

    // tags within a set stay unique
    assert property (@(posedge clk) disable iff (rst) !(hit_way0_o && hit_way1_o));

endmodule

`default_nettype wire

// ==== verilog/dcache_data_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_data_array import dcache_pkg::*; #(
    parameter int INDEX_W = 7
) (
    input  wire               clk,
    input  wire [INDEX_W-1:0] index_i,
    input  wire               cen_way0_i,
    input  wire               cen_way1_i,
    input  wire               we_i,
    input  line_t             wdata_i,
    input  line_strb_t        wstrb_i,
    output line_t             rdata_way0_o,
    output line_t             rdata_way1_o
);

    localparam int SETS = 1 << INDEX_W;

    logic [1:0] cen;

    assign cen = {cen_way1_i, cen_way0_i};

    for (genvar w = 0; w < 2; w++) begin : g_way
        line_t mem [SETS];
        line_t rdata_q;     // held until the next enabled read

        always_ff @(posedge clk) begin
            if (cen[w]) begin
                if (we_i) begin
                    for (int b = 0; b < 16; b++) begin
                        if (wstrb_i[b]) begin
                            mem[index_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
                        end
                    end
                end else begin
                    rdata_q <= mem[index_i];
                end
            end
        end
    end

    assign rdata_way0_o = g_way[0].rdata_q;
    assign rdata_way1_o = g_way[1].rdata_q;

endmodule

`default_nettype wire

// ==== verilog/dcache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl import dcache_pkg::*; #(
    parameter int INDEX_W = 7
) (
    input  wire                 clk,
    input  wire                 rst,
    // cpu side
    input  wire                 req_i,
    input  wire                 op_i,         // 0 load, 1 store
    input  addr_t               addr_i,
    input  wire [1:0]           size_i,
    input  word_strb_t          wstrb_i,
    input  word_t               wdata_i,
    output logic                req_ready_o,
    output word_t               rdata_o,
    output logic                rvalid_o,
    // memory read channel
    output logic                rd_req_o,
    output addr_t               rd_addr_o,
    output xfer_type_t          rd_type_o,
    input  wire                 rd_ready_i,
    input  word_t               rdata_i,
    input  wire                 rvalid_i,
    input  wire                 rlast_i,
    // memory write channel
    output logic                wr_req_o,
    output addr_t               wr_addr_o,
    output xfer_type_t          wr_type_o,
    output line_t               wr_data_o,
    output line_strb_t          wr_strb_o,
    input  wire                 wr_ready_i,
    // tag array
    input  wire                 hit_way0_i,
    input  wire                 hit_way1_i,
    input  wire                 victim_way_i,
    input  wire                 victim_dirty_i,
    input  wire [27-INDEX_W:0]  victim_tag_i,
    output logic [INDEX_W-1:0]  victim_index_o,
    output logic                update_o,
    output logic                update_way_o,
    output logic [27-INDEX_W:0] update_tag_o,
    output logic                set_dirty_o,
    output logic                touch_o,
    output logic                touch_way_o,
    // data array
    input  line_t               rdata_way0_i,
    input  line_t               rdata_way1_i,
    output logic [INDEX_W-1:0]  index_o,
    output logic                cen_way0_o,
    output logic                cen_way1_o,
    output logic                we_o,
    output line_t               wdata_o,
    output line_strb_t          wstrb_o
);

    dcache_state_t state_q, state_d;

    logic       accept;
    logic       cpu_hit;
    logic       req_taken_q;    // request accepted last cycle, array data valid now
    logic       need_wr;
    logic       refill_done;

    // request buffer
    addr_t      addr_q;
    logic       op_q;
    logic [1:0] size_q;
    word_strb_t wstrb_q;
    word_t      wdata_q;
    logic       hit0_q;
    logic       hit1_q;
    logic       uncached_q;

    line_t      victim_line_q;
    word_t      refill_lo_q;    // first beat of a line
    line_t      hit_line;
    line_t      fill_line;
    line_t      store_line;
    line_strb_t store_strb;
    logic [INDEX_W-1:0] req_index;

    assign accept    = req_i && req_ready_o;
    assign cpu_hit   = addr_i[31] && (hit_way0_i || hit_way1_i);
    assign req_index = addr_q[INDEX_W+3:4];

    // store data sits in the half picked by bit 3
    assign store_line = addr_q[3] ? {wdata_q, 64'd0} : {64'd0, wdata_q};
    assign store_strb = addr_q[3] ? {wstrb_q, 8'd0} : {8'd0, wstrb_q};

    assign need_wr     = uncached_q ? op_q : victim_dirty_i;
    assign refill_done = (state_q == S_REFILL) && rvalid_i && rlast_i;
    assign fill_line   = {rdata_i, refill_lo_q};
    assign hit_line    = hit1_q ? rdata_way1_i : rdata_way0_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= S_IDLE;
            req_taken_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            req_taken_q <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q     <= addr_i;
            op_q       <= op_i;
            size_q     <= size_i;
            wstrb_q    <= wstrb_i;
            wdata_q    <= wdata_i;
            hit0_q     <= hit_way0_i;
            hit1_q     <= hit_way1_i;
            uncached_q <= !addr_i[31];
        end
        if (req_taken_q) begin
            victim_line_q <= victim_way_i ? rdata_way1_i : rdata_way0_i;
        end
        if (state_q == S_REFILL && rvalid_i && !rlast_i) begin
            refill_lo_q <= rdata_i;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE, S_LOOKUP: begin
                if (accept) begin
                    state_d = cpu_hit ? S_LOOKUP : S_MISS;
                end else begin
                    state_d = S_IDLE;
                end
            end
            S_MISS: begin
                if (!need_wr) begin
                    state_d = S_REPLACE;    // clean victim, nothing to write
                end else if (wr_req_o && wr_ready_i) begin
                    state_d = (uncached_q && op_q) ? S_IDLE : S_REPLACE;
                end
            end
            S_REPLACE: begin
                if (rd_ready_i) begin
                    state_d = S_REFILL;
                end
            end
            S_REFILL: begin
                if (rvalid_i && rlast_i) begin
                    state_d = S_IDLE;
                end
            end
            default: state_d = S_IDLE;
        endcase
    end

    // a store hit holds off the next read for one cycle
    assign req_ready_o = (state_q == S_IDLE) || (state_q == S_LOOKUP && !op_q);

    // write waits one cycle in S_MISS for the victim buffer
    assign wr_req_o  = (state_q == S_MISS) && need_wr && !req_taken_q;
    assign wr_addr_o = uncached_q ? addr_q : {victim_tag_i, req_index, 4'd0};
    assign wr_type_o = uncached_q ? {1'b0, size_q} : XFER_LINE;
    assign wr_data_o = uncached_q ? store_line : victim_line_q;
    assign wr_strb_o = uncached_q ? store_strb : '1;

    assign rd_req_o  = (state_q == S_REPLACE);
    assign rd_addr_o = uncached_q ? addr_q : {addr_q[31:4], 4'd0};
    assign rd_type_o = uncached_q ? {1'b0, size_q} : XFER_LINE;

    always_comb begin
        if (state_q == S_REFILL) begin
            if (uncached_q || addr_q[3]) begin
                rdata_o = rdata_i;
            end else begin
                rdata_o = refill_lo_q;
            end
        end else begin
            rdata_o = addr_q[3] ? hit_line[127:64] : hit_line[63:0];
        end
    end

    assign rvalid_o = !op_q && ((state_q == S_LOOKUP) || refill_done);

    // tag array controls, all at the buffered index
    assign victim_index_o = req_index;
    assign update_o       = refill_done && !uncached_q;
    assign update_way_o   = victim_way_i;
    assign update_tag_o   = addr_q[31:INDEX_W+4];
    assign set_dirty_o    = op_q;
    assign touch_o        = (state_q == S_LOOKUP);
    assign touch_way_o    = hit1_q;

    always_comb begin
        index_o    = accept ? addr_i[INDEX_W+3:4] : req_index;
        cen_way0_o = 1'b0;
        cen_way1_o = 1'b0;
        we_o       = 1'b0;
        wdata_o    = store_line;
        wstrb_o    = store_strb;
        if (accept) begin
            cen_way0_o = 1'b1;  // read both ways
            cen_way1_o = 1'b1;
        end else if (state_q == S_LOOKUP && op_q) begin
            we_o       = 1'b1;
            cen_way0_o = hit0_q;
            cen_way1_o = hit1_q;
        end else if (update_o) begin
            we_o       = 1'b1;
            cen_way0_o = !victim_way_i;
            cen_way1_o = victim_way_i;
            wstrb_o    = '1;
            // pending store bytes win over the fetched line
            for (int b = 0; b < 16; b++) begin
                if (op_q && store_strb[b]) begin
                    wdata_o[b*8 +: 8] = store_line[b*8 +: 8];
                end else begin
                    wdata_o[b*8 +: 8] = fill_line[b*8 +: 8];
                end
            end
        end
    end

    // bus requests stay put until the memory takes them
    assert property (@(posedge clk) disable iff (rst)
        rd_req_o && !rd_ready_i |=> rd_req_o && $stable(rd_addr_o) && $stable(rd_type_o));
    assert property (@(posedge clk) disable iff (rst)
        wr_req_o && !wr_ready_i |=> wr_req_o && $stable(wr_addr_o) && $stable(wr_data_o)
            && $stable(wr_strb_o));

endmodule

`default_nettype wire

// ==== verilog/dcache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_top import dcache_pkg::*; #(
    parameter int INDEX_W = 7
) (
    input  wire        clk,
    input  wire        rst,
    // cpu side
    input  wire        req_i,
    input  wire        op_i,
    input  addr_t      addr_i,
    input  wire [1:0]  size_i,
    input  word_strb_t wstrb_i,
    input  word_t      wdata_i,
    output logic       req_ready_o,
    output word_t      rdata_o,
    output logic       rvalid_o,
    // memory read channel
    output logic       rd_req_o,
    output addr_t      rd_addr_o,
    output xfer_type_t rd_type_o,
    input  wire        rd_ready_i,
    input  word_t      rdata_i,
    input  wire        rvalid_i,
    input  wire        rlast_i,
    // memory write channel
    output logic       wr_req_o,
    output addr_t      wr_addr_o,
    output xfer_type_t wr_type_o,
    output line_t      wr_data_o,
    output line_strb_t wr_strb_o,
    input  wire        wr_ready_i
);

    logic                hit_way0, hit_way1;
    logic                victim_way, victim_dirty;
    logic [27-INDEX_W:0] victim_tag, update_tag;
    logic [INDEX_W-1:0]  victim_index, index;
    logic                update, update_way, set_dirty, touch, touch_way;
    logic                cen_way0, cen_way1, we;
    line_t               wdata, rdata_way0, rdata_way1;
    line_strb_t          wstrb;

    dcache_ctrl #(.INDEX_W(INDEX_W)) i_ctrl (
        .clk, .rst,
        .req_i, .op_i, .addr_i, .size_i, .wstrb_i, .wdata_i, .req_ready_o,
        .rdata_o, .rvalid_o,
        .rd_req_o, .rd_addr_o, .rd_type_o, .rd_ready_i, .rdata_i, .rvalid_i, .rlast_i,
        .wr_req_o, .wr_addr_o, .wr_type_o, .wr_data_o, .wr_strb_o, .wr_ready_i,
        .hit_way0_i     (hit_way0),
        .hit_way1_i     (hit_way1),
        .victim_way_i   (victim_way),
        .victim_dirty_i (victim_dirty),
        .victim_tag_i   (victim_tag),
        .victim_index_o (victim_index),
        .update_o       (update),
        .update_way_o   (update_way),
        .update_tag_o   (update_tag),
        .set_dirty_o    (set_dirty),
        .touch_o        (touch),
        .touch_way_o    (touch_way),
        .rdata_way0_i   (rdata_way0),
        .rdata_way1_i   (rdata_way1),
        .index_o        (index),
        .cen_way0_o     (cen_way0),
        .cen_way1_o     (cen_way1),
        .we_o           (we),
        .wdata_o        (wdata),
        .wstrb_o        (wstrb)
    );

    // lookup runs on the incoming cpu address
    dcache_tag_array #(.INDEX_W(INDEX_W)) i_tags (
        .clk, .rst,
        .lookup_addr_i  (addr_i),
        .victim_index_i (victim_index),
        .update_i       (update),
        .update_way_i   (update_way),
        .update_tag_i   (update_tag),
        .set_dirty_i    (set_dirty),
        .touch_i        (touch),
        .touch_way_i    (touch_way),
        .hit_way0_o     (hit_way0),
        .hit_way1_o     (hit_way1),
        .victim_way_o   (victim_way),
        .victim_dirty_o (victim_dirty),
        .victim_tag_o   (victim_tag)
    );

    dcache_data_array #(.INDEX_W(INDEX_W)) i_data (
        .clk,
        .index_i      (index),
        .cen_way0_i   (cen_way0),
        .cen_way1_i   (cen_way1),
        .we_i         (we),
        .wdata_i      (wdata),
        .wstrb_i      (wstrb),
        .rdata_way0_o (rdata_way0),
        .rdata_way1_o (rdata_way1)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model import dcache_pkg::*; (
    input  wire        clk,
    input  wire        rst,
    input  wire        rd_req_i,
    input  addr_t      rd_addr_i,
    input  xfer_type_t rd_type_i,
    output logic       rd_ready_o,
    output word_t      rdata_o,
    output logic       rvalid_o,
    output logic       rlast_o,
    input  wire        wr_req_i,
    input  addr_t      wr_addr_i,
    input  line_t      wr_data_i,
    input  line_strb_t wr_strb_i,
    output logic       wr_ready_o
);

    logic [7:0] mem [addr_t];  // bytes written so far

    // contents before any write, spread over the whole address
    function automatic logic [7:0] fill_byte(addr_t a);
        return 8'((a * 32'h9e3779b1) >> 24);
    endfunction

    function automatic word_t read_word(addr_t a);
        word_t w;
        for (int b = 0; b < 8; b++) begin
            w[b*8 +: 8] = mem.exists(a + 32'(b)) ? mem[a + 32'(b)] : fill_byte(a + 32'(b));
        end
        return w;
    endfunction

    task automatic write_bytes(addr_t a, line_t data, line_strb_t strb);
        addr_t base;
        base = {a[31:4], 4'd0};  // strobe is placed within the line
        for (int b = 0; b < 16; b++) begin
            if (strb[b]) begin
                mem[base + 32'(b)] = data[b*8 +: 8];
            end
        end
    endtask

    task automatic wait_cycles(int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic send_beat(word_t data, logic last);
        rdata_o  = data;
        rvalid_o = 1'b1;
        rlast_o  = last;
        @(posedge clk);
        #1;
        rvalid_o = 1'b0;
        rlast_o  = 1'b0;
    endtask

    task automatic serve_read(addr_t a, xfer_type_t t);
        wait_cycles($urandom_range(0, 3));
        if (t == XFER_LINE) begin
            send_beat(read_word({a[31:4], 4'd0}), 1'b0);  // low half first
            wait_cycles($urandom_range(0, 2));
            send_beat(read_word({a[31:4], 4'h8}), 1'b1);
        end else begin
            send_beat(read_word({a[31:3], 3'd0}), 1'b1);
        end
    endtask

    initial begin
        rd_ready_o = 1'b0;
        wr_ready_o = 1'b0;
        rdata_o    = '0;
        rvalid_o   = 1'b0;
        rlast_o    = 1'b0;
        forever begin
            @(posedge clk);
            if (!rst && wr_req_i && wr_ready_o) begin
                write_bytes(wr_addr_i, wr_data_i, wr_strb_i);
            end
            if (!rst && rd_req_i && rd_ready_o) begin
                #1;
                rd_ready_o = 1'b0;
                wr_ready_o = 1'b0;
                serve_read(rd_addr_i, rd_type_i);
            end else begin
                #1;
                rd_ready_o = 1'($urandom_range(0, 1));  // random back-pressure
                wr_ready_o = 1'($urandom_range(0, 1));
            end
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tb_dcache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dcache_top import dcache_pkg::*; ();

    localparam int     NUM_OPS       = 3000;
    localparam int     CYCLES_PER_OP = 60;
    localparam int     CLK_PERIOD    = 8;
    localparam longint WATCHDOG_NS   = longint'(NUM_OPS + 200) * CYCLES_PER_OP * CLK_PERIOD;
    localparam logic [19:0] TAGS [4] = '{20'h00000, 20'h00001, 20'h5a3c7, 20'hfffff};
    localparam logic [6:0]  SETS [3] = '{7'd1, 7'd2, 7'd77};

    logic       clk, rst;
    logic       req, op, req_ready, rvalid;
    addr_t      addr;
    logic [1:0] size;
    word_strb_t wstrb;
    word_t      wdata, rdata, mem_rdata;
    logic       rd_req, rd_ready, mem_rvalid, mem_rlast, wr_req, wr_ready;
    addr_t      rd_addr, wr_addr;
    xfer_type_t rd_type, wr_type;
    line_t      wr_data;
    line_strb_t wr_strb;

    // reference memory image and the testbench's view of resident lines
    logic [7:0]  model_mem [addr_t];
    bit          used [addr_t];
    logic [19:0] sh_tag [2][128];
    bit          sh_valid [2][128];
    bit          sh_dirty [2][128];
    bit          sh_ru [128];
    bit          hit_due;

    word_t      exp_loads [$];
    addr_t      exp_rd_addr [$];
    xfer_type_t exp_rd_type [$];
    addr_t      exp_wr_addr [$];
    xfer_type_t exp_wr_type [$];
    line_t      exp_wr_data [$];
    line_strb_t exp_wr_strb [$];

    dcache_top #(.INDEX_W(7)) i_dut (
        .clk, .rst,
        .req_i (req), .op_i (op), .addr_i (addr), .size_i (size), .wstrb_i (wstrb),
        .wdata_i (wdata), .req_ready_o (req_ready), .rdata_o (rdata), .rvalid_o (rvalid),
        .rd_req_o (rd_req), .rd_addr_o (rd_addr), .rd_type_o (rd_type), .rd_ready_i (rd_ready),
        .rdata_i (mem_rdata), .rvalid_i (mem_rvalid), .rlast_i (mem_rlast),
        .wr_req_o (wr_req), .wr_addr_o (wr_addr), .wr_type_o (wr_type), .wr_data_o (wr_data),
        .wr_strb_o (wr_strb), .wr_ready_i (wr_ready)
    );

    tb_mem_model i_mem (
        .clk, .rst,
        .rd_req_i (rd_req), .rd_addr_i (rd_addr), .rd_type_i (rd_type), .rd_ready_o (rd_ready),
        .rdata_o (mem_rdata), .rvalid_o (mem_rvalid), .rlast_o (mem_rlast),
        .wr_req_i (wr_req), .wr_addr_i (wr_addr), .wr_data_i (wr_data),
        .wr_strb_i (wr_strb), .wr_ready_o (wr_ready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic fail_run(string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_equal(string name, logic [127:0] exp, logic [127:0] act);
        if (exp !== act) begin
            fail_run($sformatf("CHECK FAILED %s expected %0h actual %0h", name, exp, act));
        end
    endtask

    // same power-up contents as the memory
    function automatic logic [7:0] initial_byte(addr_t a);
        return 8'((a * 32'h9e3779b1) >> 24);
    endfunction

    function automatic logic [7:0] model_byte(addr_t a);
        return model_mem.exists(a) ? model_mem[a] : initial_byte(a);
    endfunction

    function automatic line_t model_line(addr_t base);
        line_t l;
        for (int b = 0; b < 16; b++) begin
            l[b*8 +: 8] = model_byte(base + 32'(b));
        end
        return l;
    endfunction

    function automatic word_t model_word(addr_t a);
        line_t l;
        l = model_line({a[31:4], 4'd0});
        return a[3] ? l[127:64] : l[63:0];
    endfunction

    function automatic addr_t random_addr();
        addr_t a;
        a = {1'b0, TAGS[$urandom_range(0, 3)], SETS[$urandom_range(0, 2)],
             1'($urandom_range(0, 1)), 3'd0};
        a[31] = ($urandom_range(0, 3) != 0);  // mostly cached
        return a;
    endfunction

    task automatic push_write(addr_t a, xfer_type_t t, line_t d, line_strb_t s);
        exp_wr_addr.push_back(a);
        exp_wr_type.push_back(t);
        exp_wr_data.push_back(d);
        exp_wr_strb.push_back(s);
    endtask

    // expected bus traffic and model update for an accepted request
    task automatic handle_accept();
        int    idx;
        int    way;
        bit    hit;
        addr_t victim;
        idx = int'(addr[10:4]);
        hit = 0;
        way = 0;
        if (addr[31]) begin
            for (int w = 0; w < 2; w++) begin
                if (sh_valid[w][idx] && sh_tag[w][idx] == addr[30:11]) begin
                    hit = 1;
                    way = w;
                end
            end
            if (hit) begin
                sh_ru[idx] = (way == 1);
                if (op) sh_dirty[way][idx] = 1;
                hit_due = !op;
            end else begin
                way = !sh_valid[0][idx] ? 0 : (!sh_valid[1][idx] ? 1 : int'(!sh_ru[idx]));
                if (sh_valid[way][idx] && sh_dirty[way][idx]) begin
                    victim = {1'b1, sh_tag[way][idx], addr[10:4], 4'd0};
                    push_write(victim, XFER_LINE, model_line(victim), '1);
                end
                exp_rd_addr.push_back({addr[31:4], 4'd0});
                exp_rd_type.push_back(XFER_LINE);
                sh_valid[way][idx] = 1;
                sh_tag[way][idx]   = addr[30:11];
                sh_dirty[way][idx] = op;
                sh_ru[idx]         = (way == 1);
            end
        end else if (op) begin
            push_write(addr, {1'b0, size}, addr[3] ? {wdata, 64'd0} : {64'd0, wdata},
                       addr[3] ? {wstrb, 8'd0} : {8'd0, wstrb});
        end else begin
            exp_rd_addr.push_back(addr);
            exp_rd_type.push_back({1'b0, size});
        end
        if (op) begin
            for (int b = 0; b < 8; b++) begin
                if (wstrb[b]) model_mem[addr + 32'(b)] = wdata[b*8 +: 8];
            end
        end else begin
            exp_loads.push_back(model_word(addr));
        end
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            if (rd_req && wr_req) fail_run("read and write requested in the same cycle");
            if (hit_due && !rvalid) fail_run("load hit did not respond one cycle after acceptance");
            hit_due = 0;
            if (rvalid) begin
                if (exp_loads.size() == 0) fail_run("load response with no load outstanding");
                check_equal("load data", 128'(exp_loads.pop_front()), 128'(rdata));
            end
            if (rd_req && rd_ready) begin
                if (exp_rd_addr.size() == 0) fail_run("unexpected read request on the bus");
                check_equal("read addr", 128'(exp_rd_addr.pop_front()), 128'(rd_addr));
                check_equal("read type", 128'(exp_rd_type.pop_front()), 128'(rd_type));
            end
            if (wr_req && wr_ready) begin
                if (exp_wr_addr.size() == 0) fail_run("unexpected write request on the bus");
                check_equal("write addr", 128'(exp_wr_addr.pop_front()), 128'(wr_addr));
                check_equal("write type", 128'(exp_wr_type.pop_front()), 128'(wr_type));
                check_equal("write data", exp_wr_data.pop_front(), wr_data);
                check_equal("write strb", 128'(exp_wr_strb.pop_front()), 128'(wr_strb));
            end
            if (req && req_ready) handle_accept();
        end
    end

    // called 1 ns after an edge, returns 1 ns after the accepting edge
    task automatic drive_op(logic o, addr_t a, logic [1:0] s, word_strb_t st, word_t d);
        req   = 1'b1;
        op    = o;
        addr  = a;
        size  = s;
        wstrb = st;
        wdata = d;
        used[a] = 1;
        @(posedge clk);
        while (!req_ready) @(posedge clk);
        #1;
        req = 1'b0;
    endtask

    initial begin
        void'($urandom(32'hbc7e));
        clk = 1'b0;
        rst = 1'b1;
        req = 1'b0;
        op = 1'b0;
        addr = '0;
        size = '0;
        wstrb = '0;
        wdata = '0;
        hit_due = 0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        check_equal("ready after reset", 128'(1), 128'(req_ready));
        check_equal("rvalid after reset", 128'(0), 128'(rvalid));
        check_equal("rd_req after reset", 128'(0), 128'(rd_req));
        check_equal("wr_req after reset", 128'(0), 128'(wr_req));
        #1;
        for (int i = 0; i < NUM_OPS; i++) begin
            if ($urandom_range(0, 3) == 0) begin
                @(posedge clk);  // idle gap
                #1;
            end
            drive_op(1'($urandom_range(0, 1)), random_addr(), 2'($urandom_range(0, 3)),
                     8'($urandom_range(1, 255)), {$urandom, $urandom});
        end
        // read back every address touched
        foreach (used[a]) begin
            drive_op(1'b0, a, 2'd3, 8'd0, 64'd0);
        end
        while (exp_loads.size() != 0 || !req_ready) @(posedge clk);
        if (exp_rd_addr.size() != 0 || exp_wr_addr.size() != 0) begin
            fail_run("expected bus transfers never appeared");
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before all operations completed");
        $display("Simulation failed");
        $fatal(1);
    end

endmodule

`default_nettype wire

// ==== dcache_top.f ====
verilog/dcache_pkg.sv
verilog/dcache_tag_array.sv
verilog/dcache_data_array.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
testbench/tb_mem_model.sv
testbench/tb_dcache_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the dcache testbench with Verilator

LOG=sim.log
FAIL_MSG="Simulation failed"

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f dcache_top.f \
    --top-module tb_dcache_top -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_dcache_top > "$LOG" 2>&1
RUN_STATUS=$?
cat "$LOG"

if grep -q "$FAIL_MSG" "$LOG"; then
    exit 1
fi
if [ $RUN_STATUS -ne 0 ]; then
    echo "simulation exited with status $RUN_STATUS"
    exit 1
fi
exit 0
